// ==== Bender.yml ====
package:
  name: st_blitter

sources:
  - files:
      - design/bltPkg.sv
      - design/bltRegs.sv
      - design/bltAddrGen.sv
      - design/bltSequencer.sv
      - design/bltSkew.sv
      - design/bltCombine.sv
      - design/stBlitter.sv
  - target: simulation
    files:
      - dv/bltClkGen.sv
      - dv/bltSequencer_checker.sv
      - dv/bltTb.sv

// ==== design/bltAddrGen.sv ====
/*
 * Blitter address generator
 * X/Y word counters, source and destination address stepping, halftone line counter
 */
`timescale 1ns/1ps
`default_nettype none

module bltAddrGen (
	input logic Clks,
	input logic rst,
	input logic start,
	input logic srcLoad,
	input logic wordDone,
	input logic [bltPkg::WordW-1:1] srcXInc,
	input logic [bltPkg::WordW-1:1] srcYInc,
	input logic [bltPkg::WordW-1:1] dstXInc,
	input logic [bltPkg::WordW-1:1] dstYInc,
	input logic [bltPkg::AddrW:1] srcStart,
	input logic [bltPkg::AddrW:1] dstStart,
	input logic [bltPkg::WordW-1:0] xCount,
	input logic [bltPkg::WordW-1:0] yCount,
	input logic [bltPkg::SkewW-1:0] lineStart,
	output logic [bltPkg::AddrW:1] srcAddr,
	output logic [bltPkg::AddrW:1] dstAddr,
	output logic xFirst,
	output logic xLast,
	output logic blitLast,
	output logic [bltPkg::SkewW-1:0] lineIdx
);
	import bltPkg::*;

	localparam int ExtW = AddrW - (WordW - 1);

	logic [WordW-1:0] xCnt;
	logic [WordW-1:0] yCnt;
	logic [WordW-1:1] srcInc;
	logic [WordW-1:1] dstInc;
	logic [AddrW:1] srcStep;
	logic [AddrW:1] dstStep;

	assign xLast = (xCnt == 1);
	assign xFirst = (xCnt == xCount);	// X is reloaded at every line end
	assign blitLast = xLast & (yCnt == 1);

	// Y increment applies when leaving the last word of a line
	assign srcInc = xLast ? srcYInc : srcXInc;
	assign dstInc = xLast ? dstYInc : dstXInc;
	assign srcStep = {{ExtW{srcInc[WordW-1]}}, srcInc};
	assign dstStep = {{ExtW{dstInc[WordW-1]}}, dstInc};

	always_ff @(posedge Clks) begin
		if (rst) begin
			xCnt <= '0;
			yCnt <= '0;
			lineIdx <= '0;
		end else if (start) begin
			xCnt <= xCount;
			yCnt <= yCount;
			lineIdx <= lineStart;
		end else if (wordDone) begin
			if (xLast) begin
				xCnt <= xCount;
				yCnt <= yCnt - 1'b1;
				// Halftone line follows the destination Y direction
				lineIdx <= dstYInc[WordW-1] ? lineIdx - 1'b1 : lineIdx + 1'b1;
			end else begin
				xCnt <= xCnt - 1'b1;
			end
		end
	end

	always_ff @(posedge Clks) begin
		if (start) begin
			srcAddr <= srcStart;
			dstAddr <= dstStart;
		end else begin
			if (srcLoad)
				srcAddr <= srcAddr + srcStep;
			if (wordDone)
				dstAddr <= dstAddr + dstStep;
		end
	end

endmodule

`default_nettype wire

// ==== design/bltCombine.sv ====
/*
 * Blitter combine stage
 * Halftone RAM, HOP source select, OP logic function and end masking
 */
`timescale 1ns/1ps
`default_nettype none

module bltCombine (
	input logic Clks,
	input logic rst,
	input logic ramWr,
	input logic [bltPkg::SkewW-1:0] ramIdx,
	input logic [bltPkg::WordW-1:0] ramData,
	input logic dstLoad,
	input logic [bltPkg::WordW-1:0] memRData,
	input logic [bltPkg::WordW-1:0] skewed,
	input logic [bltPkg::SkewW-1:0] lineIdx,
	input logic xFirst,
	input logic xLast,
	input logic [1:0] hop,
	input logic [3:0] op,
	input logic [bltPkg::WordW-1:0] endMask1,
	input logic [bltPkg::WordW-1:0] endMask2,
	input logic [bltPkg::WordW-1:0] endMask3,
	output logic [bltPkg::WordW-1:0] result
);
	import bltPkg::*;

	logic [WordW-1:0] hRam [2**SkewW];
	logic [WordW-1:0] halftone;
	logic [WordW-1:0] srcVal;
	logic [WordW-1:0] mask;
	logic [WordW-1:0] combined;

	always_ff @(posedge Clks) begin
		if (ramWr)
			hRam[ramIdx] <= ramData;
	end

	assign halftone = hRam[lineIdx];

	always_comb begin
		case (hop)
			2'd0: srcVal = '1;
			2'd1: srcVal = halftone;
			2'd2: srcVal = skewed;
			default: srcVal = halftone & skewed;
		endcase
	end

	// First word mask wins on a one word line
	assign mask = xFirst ? endMask1 : (xLast ? endMask3 : endMask2);

	always_comb begin
		for (int i = 0; i < WordW; i++) begin
			combined[i] = op[{srcVal[i], memRData[i]}];	// OP indexed by S,D
			if (!mask[i])
				combined[i] = memRData[i];
		end
	end

	always_ff @(posedge Clks) begin
		if (rst)
			result <= '0;
		else if (dstLoad)
			result <= combined;
	end

endmodule

`default_nettype wire

// ==== design/bltPkg.sv ====
/*
 * Blitter package
 * Widths, host register map, control field positions and sequencer states
 */
`default_nettype none

package bltPkg;

	localparam int WordW = 16;
	localparam int AddrW = 23;	// Word address, bits 23:1
	localparam int CfgAddrW = 5;	// Bit 4 set selects the register half
	localparam int SkewW = 4;

	// Word offsets inside the register half
	localparam logic [CfgAddrW-2:0] RegSrcXInc = 4'd0;
	localparam logic [CfgAddrW-2:0] RegSrcYInc = 4'd1;
	localparam logic [CfgAddrW-2:0] RegSrcAddrHi = 4'd2;
	localparam logic [CfgAddrW-2:0] RegSrcAddrLo = 4'd3;
	localparam logic [CfgAddrW-2:0] RegEndMask1 = 4'd4;
	localparam logic [CfgAddrW-2:0] RegEndMask2 = 4'd5;
	localparam logic [CfgAddrW-2:0] RegEndMask3 = 4'd6;
	localparam logic [CfgAddrW-2:0] RegDstXInc = 4'd7;
	localparam logic [CfgAddrW-2:0] RegDstYInc = 4'd8;
	localparam logic [CfgAddrW-2:0] RegDstAddrHi = 4'd9;
	localparam logic [CfgAddrW-2:0] RegDstAddrLo = 4'd10;
	localparam logic [CfgAddrW-2:0] RegXCount = 4'd11;
	localparam logic [CfgAddrW-2:0] RegYCount = 4'd12;
	localparam logic [CfgAddrW-2:0] RegHopOp = 4'd13;
	localparam logic [CfgAddrW-2:0] RegCtrl = 4'd14;

	// Control register fields
	localparam int CtrlBusyBit = 15;
	localparam int CtrlLineLsb = 8;
	localparam int CtrlSkewLsb = 0;

	// HOP/OP register fields
	localparam int HopLsb = 8;
	localparam int OpLsb = 0;

	typedef enum logic [2:0] {
		Idle,
		RdSrc,
		RdDst,
		WrDst,
		Done
	} seqStateT;

endpackage

`default_nettype wire

// ==== design/bltRegs.sv ====
/*
 * Blitter configuration registers
 * Host write decode, busy flag, start strobe and halftone RAM write path
 */
`timescale 1ns/1ps
`default_nettype none

module bltRegs (
	input logic Clks,
	input logic rst,
	input logic cfgWr,
	input logic [bltPkg::CfgAddrW-1:0] cfgAddr,
	input logic [bltPkg::WordW-1:0] cfgData,
	input logic blitEnd,
	output logic [bltPkg::WordW-1:1] srcXInc,
	output logic [bltPkg::WordW-1:1] srcYInc,
	output logic [bltPkg::WordW-1:1] dstXInc,
	output logic [bltPkg::WordW-1:1] dstYInc,
	output logic [bltPkg::AddrW:1] srcStart,
	output logic [bltPkg::AddrW:1] dstStart,
	output logic [bltPkg::WordW-1:0] endMask1,
	output logic [bltPkg::WordW-1:0] endMask2,
	output logic [bltPkg::WordW-1:0] endMask3,
	output logic [bltPkg::WordW-1:0] xCount,
	output logic [bltPkg::WordW-1:0] yCount,
	output logic [1:0] hop,
	output logic [3:0] op,
	output logic [bltPkg::SkewW-1:0] skew,
	output logic [bltPkg::SkewW-1:0] lineStart,
	output logic busy,
	output logic start,
	output logic ramWr,
	output logic [bltPkg::SkewW-1:0] ramIdx,
	output logic [bltPkg::WordW-1:0] ramData
);
	import bltPkg::*;

	logic busyReg;
	logic regSel;
	logic regWr;
	logic ctrlWr;
	logic ctrlStart;

	assign busy = busyReg & ~blitEnd;	// Drops as soon as the sequencer finishes
	assign regSel = cfgWr & cfgAddr[CfgAddrW-1];
	assign regWr = regSel & ~busy;
	assign ctrlWr = regSel & (cfgAddr[CfgAddrW-2:0] == RegCtrl);
	assign ctrlStart = ctrlWr & cfgData[CtrlBusyBit] & ~busy;

	// Halftone writes go straight through to the RAM
	assign ramWr = cfgWr & ~cfgAddr[CfgAddrW-1] & ~busy;
	assign ramIdx = cfgAddr[SkewW-1:0];
	assign ramData = cfgData;

	always_ff @(posedge Clks) begin
		if (rst) begin
			busyReg <= 1'b0;
			start <= 1'b0;
		end else begin
			start <= ctrlStart;
			if (ctrlStart)
				busyReg <= 1'b1;	// Set wins over a same cycle blitEnd
			else if (blitEnd)
				busyReg <= 1'b0;
		end
	end

	always_ff @(posedge Clks) begin
		if (ctrlWr) begin	// Control fields stay writable during a blit
			lineStart <= cfgData[CtrlLineLsb +: SkewW];
			skew <= cfgData[CtrlSkewLsb +: SkewW];
		end
		if (regWr) begin
			case (cfgAddr[CfgAddrW-2:0])
				RegSrcXInc: srcXInc <= cfgData[WordW-1:1];
				RegSrcYInc: srcYInc <= cfgData[WordW-1:1];
				RegSrcAddrHi: srcStart[AddrW:16] <= cfgData[AddrW-16:0];
				RegSrcAddrLo: srcStart[15:1] <= cfgData[WordW-1:1];
				RegEndMask1: endMask1 <= cfgData;
				RegEndMask2: endMask2 <= cfgData;
				RegEndMask3: endMask3 <= cfgData;
				RegDstXInc: dstXInc <= cfgData[WordW-1:1];
				RegDstYInc: dstYInc <= cfgData[WordW-1:1];
				RegDstAddrHi: dstStart[AddrW:16] <= cfgData[AddrW-16:0];
				RegDstAddrLo: dstStart[15:1] <= cfgData[WordW-1:1];
				RegXCount: xCount <= cfgData;
				RegYCount: yCount <= cfgData;
				RegHopOp: begin
					hop <= cfgData[HopLsb +: 2];
					op <= cfgData[OpLsb +: 4];
				end
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== design/bltSequencer.sv ====
/*
 * Blitter word sequencer
 * Per word optional source read, destination read and write on the memory port
 */
`timescale 1ns/1ps
`default_nettype none

module bltSequencer (
	input logic Clks,
	input logic rst,
	input logic start,
	input logic [1:0] hop,
	input logic xLast,
	input logic blitLast,
	input logic memRValid,
	input logic [bltPkg::AddrW:1] srcAddr,
	input logic [bltPkg::AddrW:1] dstAddr,
	input logic [bltPkg::WordW-1:0] result,
	output logic memReq,
	output logic memWe,
	output logic [bltPkg::AddrW:1] memAddr,
	output logic [bltPkg::WordW-1:0] memWData,
	output logic srcLoad,
	output logic dstLoad,
	output logic wordDone,
	output logic blitEnd
);
	import bltPkg::*;

	seqStateT state;
	seqStateT nextState;
	seqStateT firstState;
	logic waiting;	// Read issued, data not back yet
	logic isRead;
	logic lastWord;

	assign isRead = (state == RdSrc) | (state == RdDst);
	assign firstState = hop[1] ? RdSrc : RdDst;	// HOP 0 and 1 never use source
	assign lastWord = xLast & blitLast;

	assign memReq = (isRead & ~waiting) | (state == WrDst);
	assign memWe = (state == WrDst);
	assign memAddr = (state == RdSrc) ? srcAddr : dstAddr;
	assign memWData = result;
	assign srcLoad = (state == RdSrc) & memRValid;
	assign dstLoad = (state == RdDst) & memRValid;
	assign wordDone = (state == WrDst);
	assign blitEnd = (state == Done);

	always_comb begin
		nextState = state;
		case (state)
			Idle: if (start) nextState = firstState;
			RdSrc: if (memRValid) nextState = RdDst;
			RdDst: if (memRValid) nextState = WrDst;
			WrDst: nextState = lastWord ? Done : firstState;
			Done: nextState = Idle;
			default: nextState = Idle;
		endcase
	end

	always_ff @(posedge Clks) begin
		if (rst) begin
			state <= Idle;
			waiting <= 1'b0;
		end else begin
			state <= nextState;
			if (memRValid)
				waiting <= 1'b0;
			else if (isRead)
				waiting <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== design/bltSkew.sv ====
/*
 * Blitter skew stage
 * Two word source buffer and the right barrel shift by skew
 */
`timescale 1ns/1ps
`default_nettype none

module bltSkew (
	input logic Clks,
	input logic rst,
	input logic start,
	input logic srcLoad,
	input logic [bltPkg::WordW-1:0] memRData,
	input logic [bltPkg::WordW-1:1] srcXInc,
	input logic [bltPkg::SkewW-1:0] skew,
	output logic [bltPkg::WordW-1:0] skewed
);
	import bltPkg::*;

	logic [2*WordW-1:0] skewBuf;
	logic [2*WordW-1:0] shifted;

	always_ff @(posedge Clks) begin
		if (rst || start)
			skewBuf <= '0;	// Each blit begins with an empty buffer
		else if (srcLoad) begin
			if (srcXInc[WordW-1])	// Right to left source
				skewBuf <= {memRData, skewBuf[2*WordW-1:WordW]};
			else
				skewBuf <= {skewBuf[WordW-1:0], memRData};
		end
	end

	assign shifted = skewBuf >> skew;
	assign skewed = shifted[WordW-1:0];

endmodule

`default_nettype wire

// ==== design/stBlitter.sv ====
/*
 * Raster blitter top level
 * Registers, address generator, sequencer, skew and combine stages
 */
`timescale 1ns/1ps
`default_nettype none

module stBlitter (
	input logic Clks,
	input logic rst,
	input logic cfgWr,
	input logic [bltPkg::CfgAddrW-1:0] cfgAddr,
	input logic [bltPkg::WordW-1:0] cfgData,
	input logic memRValid,
	input logic [bltPkg::WordW-1:0] memRData,
	output logic memReq,
	output logic memWe,
	output logic [bltPkg::AddrW:1] memAddr,
	output logic [bltPkg::WordW-1:0] memWData,
	output logic busy
);
	import bltPkg::*;

	logic [WordW-1:1] srcXInc, srcYInc, dstXInc, dstYInc;
	logic [AddrW:1] srcStart, dstStart, srcAddr, dstAddr;
	logic [WordW-1:0] endMask1, endMask2, endMask3;
	logic [WordW-1:0] xCount, yCount;
	logic [1:0] hop;
	logic [3:0] op;
	logic [SkewW-1:0] skew, lineStart, lineIdx, ramIdx;
	logic start, blitEnd, ramWr;
	logic [WordW-1:0] ramData, skewed, result;
	logic srcLoad, dstLoad, wordDone;
	logic xFirst, xLast, blitLast;

	bltRegs bltRegs_i (.Clks, .rst, .cfgWr, .cfgAddr, .cfgData, .blitEnd,
		.srcXInc, .srcYInc, .dstXInc, .dstYInc, .srcStart, .dstStart,
		.endMask1, .endMask2, .endMask3, .xCount, .yCount, .hop, .op, .skew,
		.lineStart, .busy, .start, .ramWr, .ramIdx, .ramData);

	bltAddrGen bltAddrGen_i (.Clks, .rst, .start, .srcLoad, .wordDone,
		.srcXInc, .srcYInc, .dstXInc, .dstYInc, .srcStart, .dstStart,
		.xCount, .yCount, .lineStart, .srcAddr, .dstAddr, .xFirst, .xLast,
		.blitLast, .lineIdx);

	bltSequencer bltSequencer_i (.Clks, .rst, .start, .hop, .xLast, .blitLast,
		.memRValid, .srcAddr, .dstAddr, .result, .memReq, .memWe, .memAddr,
		.memWData, .srcLoad, .dstLoad, .wordDone, .blitEnd);

	bltSkew bltSkew_i (.Clks, .rst, .start, .srcLoad, .memRData, .srcXInc,
		.skew, .skewed);

	bltCombine bltCombine_i (.Clks, .rst, .ramWr, .ramIdx, .ramData, .dstLoad,
		.memRData, .skewed, .lineIdx, .xFirst, .xLast, .hop, .op,
		.endMask1, .endMask2, .endMask3, .result);

endmodule

`default_nettype wire

// ==== dv/bltClkGen.sv ====
/*
 * Testbench clock and reset
 * 40 ns clock, reset held for the first 3 cycles
 */
`timescale 1ns/1ps
`default_nettype none

module bltClkGen (
	output logic Clks,
	output logic rst
);

	initial begin
		Clks = 1'b0;
		forever #20 Clks = ~Clks;	// 40 ns period
	end

	initial begin
		rst = 1'b1;
		repeat (3) @(posedge Clks);
		#2;
		rst = 1'b0;
	end

endmodule

`default_nettype wire

// ==== dv/bltSequencer_checker.sv ====
/*
 * Sequencer checker
 * Memory strobe rules, single outstanding read and end of blit timing
 */
`timescale 1ns/1ps
`default_nettype none

module bltSequencer_checker (
	input logic Clks,
	input logic rst,
	input logic memReq,
	input logic memWe,
	input logic memRValid,
	input logic blitLast,
	input logic blitEnd,
	input bltPkg::seqStateT state
);
	import bltPkg::*;

	logic readOwed;	// Read data still owed by the memory
	logic wordOpen;	// Word read but not yet written back

	always_ff @(posedge Clks) begin
		if (rst) begin
			readOwed <= 1'b0;
			wordOpen <= 1'b0;
		end else begin
			if (memRValid)
				readOwed <= 1'b0;
			else if (memReq && !memWe)
				readOwed <= 1'b1;
			if (memReq)
				wordOpen <= !memWe;
		end
	end

	// Write goes out the cycle after the destination data
	weWithReq: assert property (@(posedge Clks) disable iff (rst)
		memWe |-> memReq && $past(memRValid))
		else $error("memWe asserted without memReq or destination data");

	oneRead: assert property (@(posedge Clks) disable iff (rst)
		(memReq && !memWe) |-> !readOwed)
		else $error("memReq issued while a read is outstanding");

	endInDone: assert property (@(posedge Clks) disable iff (rst)
		blitEnd |-> state == Done && $past(memWe && blitLast))
		else $error("blitEnd outside the Done state after the last write");

	busyHeld: assert property (@(posedge Clks) disable iff (rst)
		blitEnd |-> !wordOpen)
		else $error("busy dropped while a write is pending");

endmodule

bind bltSequencer bltSequencer_checker bltSequencer_checker_i (
	.Clks,
	.rst,
	.memReq,
	.memWe,
	.memRValid,
	.blitLast,
	.blitEnd,
	.state
);

`default_nettype wire

// ==== dv/bltTb.sv ====
/*
 * Blitter testbench
 * Random blits against a reference model, with a memory model of random latency
 */
`timescale 1ns/1ps
`default_nettype none

module bltTb;
	import bltPkg::*;

	logic Clks;
	logic rst;
	logic cfgWr;
	logic [CfgAddrW-1:0] cfgAddr;
	logic [WordW-1:0] cfgData;
	logic memRValid;
	logic [WordW-1:0] memRData;
	logic memReq;
	logic memWe;
	logic [AddrW:1] memAddr;
	logic [WordW-1:0] memWData;
	logic busy;

	integer seed;
	logic [WordW-1:0] mem [4096];	// Indexed by the low 12 address bits
	logic [WordW-1:0] shadow [4096];
	logic [AddrW-1:0] expAddr [$];
	logic [WordW-1:0] expData [$];
	logic [AddrW-1:0] rdAddr;
	int rdWait;
	int wrCount;
	int rdCount;
	int checkCount;
	int errCount;
	int timeoutCount;
	logic timedOut;

	// Parameters of the current blit
	int xN, yN, sxi, syi, dxi, dyi;
	logic [AddrW-1:0] sBase, dBase;
	logic [1:0] hop;
	logic [3:0] op;
	logic [SkewW-1:0] skew, lineStart;
	logic [WordW-1:0] m1, m2, m3;
	logic [WordW-1:0] ht [16];

	bltClkGen clkGen_i (.Clks, .rst);

	stBlitter stBlitter_i (.Clks, .rst, .cfgWr, .cfgAddr, .cfgData, .memRValid, .memRData,
		.memReq, .memWe, .memAddr, .memWData, .busy);

	function automatic int pickInc(input int maxMag);
		int mag;
		mag = 1 + ({$random(seed)} % maxMag);
		return ($random(seed) & 1) ? -mag : mag;
	endfunction

	task automatic compareWord(input string sig, input logic [31:0] exp, input logic [31:0] got);
		checkCount++;
		assert (exp == got) else begin
			errCount++;
			$display("FAIL %s exp %h got %h", sig, exp, got);
		end
	endtask

	task automatic noteTimeout(input string what);
		$display("Timeout waiting for %s", what);
		timeoutCount++;
		timedOut = 1'b1;
	endtask

	task automatic cfgWrite(input logic [CfgAddrW-1:0] addr, input logic [WordW-1:0] data);
		@(posedge Clks);
		#2;
		cfgWr = 1'b1;
		cfgAddr = addr;
		cfgData = data;
		@(posedge Clks);
		#2;
		cfgWr = 1'b0;
	endtask

	// Memory answers each read 1 to 4 cycles after the request
	always @(posedge Clks) begin
		#2;
		memRValid = 1'b0;
		if (rdWait != 0) begin
			rdWait = rdWait - 1;
			if (rdWait == 0) begin
				memRValid = 1'b1;
				memRData = mem[rdAddr[11:0]];
			end
		end
	end

	always @(negedge Clks) begin
		if (!rst && memReq) begin
			if (memWe) begin
				wrCount++;
				if (expAddr.size() == 0) begin
					errCount++;
					$display("Unexpected write to address %h", memAddr);
				end else begin
					compareWord("memAddr", expAddr.pop_front(), memAddr);
					compareWord("memWData", expData.pop_front(), memWData);
				end
				mem[memAddr[12:1]] = memWData;
			end else begin
				rdCount++;
				rdAddr = memAddr;
				rdWait = 1 + ({$random(seed)} % 4);
			end
		end
	end

	// Walks the blit word by word on a copy of memory
	task automatic buildModel();
		logic [AddrW-1:0] sa, da;
		logic [31:0] sbuf, sh;
		logic [WordW-1:0] srcWord, sv, d, r, mask;
		logic [SkewW-1:0] line;
		logic xl;
		for (int i = 0; i < 4096; i++)
			shadow[i] = mem[i];
		sa = sBase;
		da = dBase;
		sbuf = '0;
		line = lineStart;
		expAddr.delete();
		expData.delete();
		for (int y = 0; y < yN; y++) begin
			for (int x = 0; x < xN; x++) begin
				xl = (x == xN - 1);
				if (hop[1]) begin
					srcWord = shadow[sa[11:0]];
					sbuf = (sxi < 0) ? {srcWord, sbuf[31:16]} : {sbuf[15:0], srcWord};
					sa = sa + (xl ? syi : sxi);
				end
				sh = sbuf >> skew;
				case (hop)
					2'd0: sv = '1;
					2'd1: sv = ht[line];
					2'd2: sv = sh[15:0];
					default: sv = ht[line] & sh[15:0];
				endcase
				mask = (x == 0) ? m1 : (xl ? m3 : m2);
				d = shadow[da[11:0]];
				r = (~sv & ~d & {16{op[0]}}) | (~sv & d & {16{op[1]}})
					| (sv & ~d & {16{op[2]}}) | (sv & d & {16{op[3]}});
				r = (r & mask) | (d & ~mask);
				shadow[da[11:0]] = r;
				expAddr.push_back(da);
				expData.push_back(r);
				da = da + (xl ? dyi : dxi);
			end
			line = (dyi < 0) ? line - 1'b1 : line + 1'b1;
		end
	endtask

	task automatic runBlit(input int n);
		logic [31:0] rnd;
		int lat;
		int waitCnt;
		xN = 1 + ({$random(seed)} % 4);
		yN = 1 + ({$random(seed)} % 3);
		sxi = pickInc(4);
		dxi = pickInc(4);
		syi = pickInc(32);
		dyi = pickInc(32);
		rnd = $random(seed);
		sBase = {rnd[10:0], 12'h400};
		dBase = {rnd[21:11], 12'hc00};	// Source and destination never alias
		rnd = $random(seed);
		hop = rnd[1:0];
		op = rnd[5:2];
		skew = rnd[9:6];
		lineStart = rnd[13:10];
		if (n < 10) begin	// Plain source copies first
			hop = 2'd2;
			skew = '0;
		end
		m1 = $random(seed);
		m2 = $random(seed);
		m3 = $random(seed);
		for (int i = 0; i < 16; i++) begin
			ht[i] = $random(seed);
			cfgWrite({1'b0, i[3:0]}, ht[i]);
		end
		cfgWrite({1'b1, RegSrcXInc}, {sxi[14:0], 1'b0});
		cfgWrite({1'b1, RegSrcYInc}, {syi[14:0], 1'b0});
		cfgWrite({1'b1, RegSrcAddrHi}, {8'd0, sBase[22:15]});
		cfgWrite({1'b1, RegSrcAddrLo}, {sBase[14:0], 1'b0});
		cfgWrite({1'b1, RegEndMask1}, m1);
		cfgWrite({1'b1, RegEndMask2}, m2);
		cfgWrite({1'b1, RegEndMask3}, m3);
		cfgWrite({1'b1, RegDstXInc}, {dxi[14:0], 1'b0});
		cfgWrite({1'b1, RegDstYInc}, {dyi[14:0], 1'b0});
		cfgWrite({1'b1, RegDstAddrHi}, {8'd0, dBase[22:15]});
		cfgWrite({1'b1, RegDstAddrLo}, {dBase[14:0], 1'b0});
		cfgWrite({1'b1, RegXCount}, xN[15:0]);
		cfgWrite({1'b1, RegYCount}, yN[15:0]);
		cfgWrite({1'b1, RegHopOp}, ({14'd0, hop} << HopLsb) | ({12'd0, op} << OpLsb));
		buildModel();
		wrCount = 0;
		rdCount = 0;
		cfgWrite({1'b1, RegCtrl}, (16'd1 << CtrlBusyBit) | ({12'd0, lineStart} << CtrlLineLsb)
			| ({12'd0, skew} << CtrlSkewLsb));
		lat = 0;
		while (!memReq && lat < 10) begin
			@(negedge Clks);
			lat++;
		end
		if (!memReq) begin
			noteTimeout("the first memReq of a blit");
			return;
		end
		checkCount++;
		assert (lat == 2) else begin
			errCount++;
			$display("First memReq of blit %0d came %0d cycles after start, expected 2", n, lat);
		end
		waitCnt = 0;
		while (busy && waitCnt < 600) begin
			@(negedge Clks);
			waitCnt++;
		end
		if (busy) begin
			noteTimeout("busy to fall");
			return;
		end
		checkCount++;
		assert (wrCount == xN * yN && expAddr.size() == 0) else begin
			errCount++;
			$display("Blit %0d made %0d writes, expected %0d", n, wrCount, xN * yN);
		end
		checkCount++;
		assert (rdCount == (hop[1] ? 2 : 1) * xN * yN) else begin
			errCount++;
			$display("Blit %0d made %0d reads with HOP %0d", n, rdCount, hop);
		end
	endtask

	initial begin
		int waitCnt;
		cfgWr = 1'b0;
		cfgAddr = '0;
		cfgData = '0;
		memRValid = 1'b0;
		memRData = '0;
		rdWait = 0;
		seed = 32'h00c8_7751;
		checkCount = 0;
		errCount = 0;
		timeoutCount = 0;
		timedOut = 1'b0;
		for (int i = 0; i < 4096; i++)
			mem[i] = $random(seed);
		waitCnt = 0;
		while (rst !== 1'b0 && waitCnt < 20) begin
			@(negedge Clks);
			waitCnt++;
		end
		if (rst !== 1'b0)
			noteTimeout("reset release");
		for (int n = 0; n < 40 && !timedOut; n++)
			runBlit(n);
		$display("Checks %0d, mismatches %0d, timeouts %0d", checkCount, errCount, timeoutCount);
		if (errCount == 0 && timeoutCount == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== flist.f ====
design/bltPkg.sv
design/bltRegs.sv
design/bltAddrGen.sv
design/bltSequencer.sv
design/bltSkew.sv
design/bltCombine.sv
design/stBlitter.sv
dv/bltClkGen.sv
dv/bltSequencer_checker.sv
dv/bltTb.sv
